/* mbox_pkg.sv */
package mbox_pkg;

   // ##############################
   // widths
   // ##############################
   localparam int PKT_W    = 104;     // mesh packet
   localparam int ADDR_W   = 32;      // mesh address
   localparam int HALF_W   = 32;      // one register half
   localparam int WORD_W   = 2*HALF_W; // full mailbox word
   localparam int RFAW     = 6;       // register index width

   // packet field positions
   localparam int PKT_WR_BIT   = 1;                          // write flag
   localparam int PKT_ADDR_LSB = 8;
   localparam int PKT_ADDR_MSB = PKT_ADDR_LSB + ADDR_W - 1;  // 39
   localparam int PKT_DATA_LSB = 40;
   localparam int PKT_DATA_MSB = PKT_DATA_LSB + WORD_W - 1;  // 103

   // address sub-fields
   localparam int ADDR_NODE_LSB = 20;  // node id lives in 31:20
   localparam int ADDR_GRP_LSB  = 8;   // register group in 10:8
   localparam int REG_IDX_LSB   = 2;   // word index, byte addr drops 2 bits

   // ##############################
   // vector types
   // ##############################
   typedef logic [PKT_W-1:0]  packet_t;
   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [HALF_W-1:0] half_t;
   typedef logic [WORD_W-1:0] mbox_word_t;
   typedef logic [RFAW-1:0]   reg_idx_t;
   typedef logic [RFAW+1:0]   mi_addr_t;  // byte address, idx in upper bits

   // this node and its mailbox decode
   localparam logic [11:0] NODE_ID    = 12'h810;
   localparam logic [2:0]  MBOX_GROUP = 3'h3;

   localparam reg_idx_t REG_MBOX_LO = 6'd9;   // peek head
   localparam reg_idx_t REG_MBOX_HI = 6'd10;  // read head and pop

   // ##############################
   // fifo sizing
   // ##############################
   localparam int FIFO_DEPTH = 16;
   localparam int FIFO_AW    = 4;   // log2 depth

   // one extra bit so a full fifo reads 16, not 0
   typedef logic [FIFO_AW:0] count_t;

endpackage

/* mbox_word_if.sv */
`timescale 1ns/10ps

// one mailbox word with valid/ready handshake
// transfer happens on an edge with valid and ready both high
interface mbox_word_if
   import mbox_pkg::*;
   ();

   logic  valid;  // source has a word
   logic  ready;  // sink takes it this edge
   half_t lo;     // bits 31:0 of the word
   half_t hi;     // bits 63:32

   // producer side
   modport src (
      output valid,
      output lo,
      output hi,
      input  ready
   );

   // consumer side, mirror of src
   modport dst (
      input  valid,
      input  lo,
      input  hi,
      output ready
   );

endinterface

/* mesh_write_filter.sv */
`timescale 1ns/10ps

module mesh_write_filter
   import mbox_pkg::*;
   (
   input  logic     rd_clk,
   input  logic     rd_reset,
   input  logic     mesh_access,   // packet strobe
   input  packet_t  mesh_packet,
   output logic     packet_wait,   // upstream must hold off
   mbox_word_if.src push           // toward the fifo
   );

   // ##############################
   // packet decode
   // ##############################
   addr_t      pkt_addr;
   mbox_word_t pkt_data;
   logic       pkt_write;
   logic       node_hit;
   logic       group_hit;
   logic       reg_hit;
   logic       mbox_write;   // packet targets our mailbox
   logic       accept;       // load the output register

   // one-entry holding register
   logic       held_full;
   mbox_word_t held_word;

   assign pkt_addr  = mesh_packet[PKT_ADDR_MSB:PKT_ADDR_LSB];
   assign pkt_data  = mesh_packet[PKT_DATA_MSB:PKT_DATA_LSB];
   assign pkt_write = mesh_packet[PKT_WR_BIT];

   assign node_hit  = (pkt_addr[ADDR_W-1:ADDR_NODE_LSB] == NODE_ID);
   assign group_hit = (pkt_addr[ADDR_GRP_LSB +: 3] == MBOX_GROUP);
   assign reg_hit   = (pkt_addr[REG_IDX_LSB +: RFAW] == REG_MBOX_LO); // writes land on lo

   assign mbox_write = pkt_write & node_hit & group_hit & reg_hit;

   // stall only when a word is stuck and the fifo says no
   assign packet_wait = held_full & ~push.ready;

   // packets arriving during a stall are lost, caller's job
   assign accept = mesh_access & ~packet_wait & mbox_write;

   // ##############################
   // output register
   // ##############################
   always_ff @(posedge rd_clk) begin
      if (rd_reset) begin
         held_full <= 1'b0;
      end else if (accept) begin
         held_full <= 1'b1;               // refill, even if old word leaves now
      end else if (push.ready) begin
         held_full <= 1'b0;               // fifo took it, or was empty anyway
      end
   end

   always_ff @(posedge rd_clk) begin
      if (accept) begin
         held_word <= pkt_data;
      end
   end

   assign push.valid = held_full;
   assign push.lo    = held_word[HALF_W-1:0];
   assign push.hi    = held_word[WORD_W-1:HALF_W];

   // stalled word must not change under the fifo
   a_push_stable: assert property (@(posedge rd_clk) disable iff (rd_reset)
      push.valid && !push.ready |=> push.valid && $stable({push.hi, push.lo}))
      else $error("filter changed a stalled word");

endmodule

/* mailbox_fifo.sv */
`timescale 1ns/10ps

module mailbox_fifo
   import mbox_pkg::*;
   (
   input  logic     rd_clk,
   input  logic     rd_reset,
   mbox_word_if.dst push,              // from the filter
   mbox_word_if.src pop,               // to the register reader
   output logic     mailbox_full,      // status flag
   output logic     mailbox_not_empty  // level interrupt
   );

   // ##############################
   // storage and pointers
   // ##############################
   mbox_word_t          mem [FIFO_DEPTH];
   logic [FIFO_AW-1:0]  wr_ptr;
   logic [FIFO_AW-1:0]  rd_ptr;
   count_t              count;
   count_t              count_next;
   logic                full_q;
   logic                not_empty;
   logic                do_push;
   logic                do_pop;

   assign do_push = push.valid & push.ready;
   assign do_pop  = pop.valid & pop.ready;

   // push and pop together cancel out
   always_comb begin
      count_next = count + count_t'(do_push) - count_t'(do_pop);
   end

   // write side, no reset on the array
   always_ff @(posedge rd_clk) begin
      if (do_push) begin
         mem[wr_ptr] <= {push.hi, push.lo};
      end
   end

   // pointers wrap on their own at depth 16
   always_ff @(posedge rd_clk) begin
      if (rd_reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // ##############################
   // occupancy
   // ##############################
   always_ff @(posedge rd_clk) begin
      if (rd_reset) begin
         count  <= '0;
         full_q <= 1'b0;
      end else begin
         count  <= count_next;
         // from next count so ready drops on the same edge the last slot fills
         full_q <= (count_next == count_t'(FIFO_DEPTH));
      end
   end

   assign not_empty = (count != '0);

   assign push.ready = ~full_q;   // pop while full still allowed

   // head entry is always on the pop side
   assign pop.valid = not_empty;
   assign pop.lo    = mem[rd_ptr][HALF_W-1:0];
   assign pop.hi    = mem[rd_ptr][WORD_W-1:HALF_W];

   assign mailbox_full      = full_q;
   assign mailbox_not_empty = not_empty;

   // ##############################
   // checks
   // ##############################
   a_no_overflow: assert property (@(posedge rd_clk) disable iff (rd_reset)
      push.valid && push.ready |-> count < count_t'(FIFO_DEPTH))
      else $error("push into full mailbox fifo");

   // hi read on an empty fifo leaves the read side alone
   a_no_underflow: assert property (@(posedge rd_clk) disable iff (rd_reset)
      pop.ready && count == '0 |=> $stable(rd_ptr))
      else $error("pop from empty mailbox fifo");

   a_count_range: assert property (@(posedge rd_clk) disable iff (rd_reset)
      count <= count_t'(FIFO_DEPTH))
      else $error("mailbox count above depth");

endmodule

/* mailbox_reg_reader.sv */
`timescale 1ns/10ps

module mailbox_reg_reader
   import mbox_pkg::*;
   (
   input  logic       rd_clk,
   input  logic       rd_reset,
   input  logic       mi_en,    // register access strobe
   input  logic       mi_we,    // writes are accepted and ignored
   input  mi_addr_t   mi_addr,  // byte address
   output mbox_word_t mi_dout,  // one cycle after the read
   mbox_word_if.dst   pop       // head of the fifo
   );

   // ##############################
   // address decode
   // ##############################
   reg_idx_t rd_idx;
   logic     mi_rd;
   logic     rd_lo;       // peek
   logic     rd_hi;       // read and pop
   logic     load_head;   // capture head into mi_dout

   assign rd_idx = mi_addr[REG_IDX_LSB +: RFAW];   // byte lanes dropped
   assign mi_rd  = mi_en & ~mi_we;
   assign rd_lo  = mi_rd & (rd_idx == REG_MBOX_LO);
   assign rd_hi  = mi_rd & (rd_idx == REG_MBOX_HI);

   // hi read drains the entry, fifo ignores it when empty
   assign pop.ready = rd_hi;

   assign load_head = (rd_lo | rd_hi) & pop.valid;

   // ##############################
   // read data register
   // ##############################
   // head sampled on the read edge, before the pop takes effect
   always_ff @(posedge rd_clk) begin
      if (rd_reset) begin
         mi_dout <= '0;
      end else if (load_head) begin
         mi_dout <= {pop.hi, pop.lo};
      end else begin
         mi_dout <= '0;     // idle, other index, write or empty fifo
      end
   end

   // ##############################
   // checks
   // ##############################
   // pop strobe traced back to the raw register bus
   a_pop_only_on_hi: assert property (@(posedge rd_clk) disable iff (rd_reset)
      pop.ready |-> mi_en && !mi_we && (mi_addr[REG_IDX_LSB +: RFAW] == REG_MBOX_HI))
      else $error("fifo pop without a high register read");

endmodule

/* emailbox_top.sv */
`timescale 1ns/10ps

module emailbox_top
   import mbox_pkg::*;
   (
   input  logic       rd_clk,
   input  logic       rd_reset,

   // mesh packet input
   input  logic       mesh_access,
   input  packet_t    mesh_packet,
   output logic       packet_wait,

   // register read port
   input  logic       mi_en,
   input  logic       mi_we,
   input  mi_addr_t   mi_addr,
   output mbox_word_t mi_dout,

   // status, not_empty doubles as irq
   output logic       mailbox_full,
   output logic       mailbox_not_empty
   );

   // ##############################
   // internal links
   // ##############################
   mbox_word_if push_if ();   // filter -> fifo
   mbox_word_if pop_if ();    // fifo -> reader

   // packet decode and hold
   mesh_write_filter u_filter (
      .rd_clk      (rd_clk),
      .rd_reset    (rd_reset),
      .mesh_access (mesh_access),
      .mesh_packet (mesh_packet),
      .packet_wait (packet_wait),
      .push        (push_if.src)
   );

   // 16 deep word buffer
   mailbox_fifo u_fifo (
      .rd_clk            (rd_clk),
      .rd_reset          (rd_reset),
      .push              (push_if.dst),
      .pop               (pop_if.src),
      .mailbox_full      (mailbox_full),
      .mailbox_not_empty (mailbox_not_empty)
   );

   // lo/hi register reads
   mailbox_reg_reader u_reader (
      .rd_clk   (rd_clk),
      .rd_reset (rd_reset),
      .mi_en    (mi_en),
      .mi_we    (mi_we),
      .mi_addr  (mi_addr),
      .mi_dout  (mi_dout),
      .pop      (pop_if.dst)
   );

endmodule

/* tb_emailbox.sv */
`timescale 1ns/10ps

module tb_emailbox
   import mbox_pkg::*;
   ();

   // ##############################
   // dut signals
   // ##############################
   logic       rd_clk = 1'b0;
   logic       rd_reset;
   logic       mesh_access;
   packet_t    mesh_packet;
   logic       packet_wait;
   logic       mi_en;
   logic       mi_we;
   mi_addr_t   mi_addr;
   mbox_word_t mi_dout;
   logic       mailbox_full;
   logic       mailbox_not_empty;

   typedef enum logic [2:0] {
      OP_IDLE,
      OP_SEND,      // wait out packet_wait, then send
      OP_DROP,      // sent on purpose while packet_wait is high
      OP_RD_LO,     // peek
      OP_RD_HI,     // read and pop
      OP_RD_OTHER,  // read of a non-mailbox index
      OP_REG_WR     // register write, no effect
   } op_e;

   typedef struct packed {
      op_e   op;
      addr_t addr;   // mesh address, or register byte address in 7:0
      logic  wr;     // packet write flag
      logic  match;  // packet should land in the mailbox
   } row_t;

   row_t       rows[$];
   mbox_word_t model_q[$];   // expected contents, oldest first
   int         cycle_cnt   = 0;
   int         cycle_limit = 100;

   emailbox_top u_dut (
      .rd_clk            (rd_clk),
      .rd_reset          (rd_reset),
      .mesh_access       (mesh_access),
      .mesh_packet       (mesh_packet),
      .packet_wait       (packet_wait),
      .mi_en             (mi_en),
      .mi_we             (mi_we),
      .mi_addr           (mi_addr),
      .mi_dout           (mi_dout),
      .mailbox_full      (mailbox_full),
      .mailbox_not_empty (mailbox_not_empty)
   );

   always #2 rd_clk = ~rd_clk;   // 4 ns period

   // ##############################
   // helpers
   // ##############################
   task automatic abort_run(string why);
      $display("Simulation failed");
      $fatal(1, "%s", why);
   endtask

   task automatic compare_word(string name, logic [63:0] got, logic [63:0] exp);
      assert (got === exp) else begin
         $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
         abort_run("stopped at first mismatch");
      end
   endtask

   // node id in 31:20, group in 10:8, word index in 7:2
   function automatic addr_t mesh_addr(logic [11:0] node, logic [2:0] grp, reg_idx_t idx);
      addr_t a;
      a        = '0;
      a[31:20] = node;
      a[10:8]  = grp;
      a[7:2]   = idx;
      return a;
   endfunction

   function automatic addr_t reg_addr(reg_idx_t idx);
      return {24'h0, idx, 2'b00};   // byte address of a word register
   endfunction

   function automatic packet_t make_packet(addr_t a, logic wr, mbox_word_t data);
      packet_t     p;
      logic [31:0] junk;
      junk      = $urandom;
      p         = '0;
      p[103:40] = data;
      p[39:8]   = a;
      p[7:2]    = junk[5:0];   // don't care fields
      p[1]      = wr;
      p[0]      = junk[6];
      return p;
   endfunction

   function automatic void add_row(op_e op, addr_t a, logic wr, logic match);
      row_t r;
      r.op    = op;
      r.addr  = a;
      r.wr    = wr;
      r.match = match;
      rows.push_back(r);
   endfunction

   // flags follow the model depth, one extra word parks in the filter
   task automatic verify_status();
      int n;
      n = model_q.size();
      compare_word("mailbox_not_empty", 64'(mailbox_not_empty), 64'(n != 0));
      compare_word("mailbox_full", 64'(mailbox_full), 64'(n >= FIFO_DEPTH));
      compare_word("packet_wait", 64'(packet_wait), 64'(n > FIFO_DEPTH));
      compare_word("mi_dout", mi_dout, 64'h0);   // no read pending
   endtask

   task automatic send_packet(row_t r);
      mbox_word_t data;
      logic       blocked;
      if (r.op == OP_DROP) begin
         assert (packet_wait) else begin
            abort_run("drop row reached while packet_wait was low");
         end
      end else begin
         while (packet_wait) @(negedge rd_clk);   // respect back-pressure
      end
      data        = {$urandom, $urandom};
      blocked     = packet_wait;
      mesh_access = 1'b1;
      mesh_packet = make_packet(r.addr, r.wr, data);
      @(negedge rd_clk);
      mesh_access = 1'b0;
      if (r.match && !blocked) begin
         model_q.push_back(data);
      end
      repeat (2) @(negedge rd_clk);   // filter register, then fifo write
      verify_status();
   endtask

   task automatic reg_access(row_t r);
      mbox_word_t exp;
      logic       is_read;
      is_read = (r.op == OP_RD_LO) || (r.op == OP_RD_HI);
      exp     = '0;
      if (is_read && model_q.size() != 0) begin
         exp = model_q[0];   // head at the read edge
      end
      mi_en   = 1'b1;
      mi_we   = (r.op == OP_REG_WR);
      mi_addr = r.addr[7:0];
      @(negedge rd_clk);
      mi_en = 1'b0;
      mi_we = 1'b0;
      compare_word("mi_dout", mi_dout, exp);
      if (r.op == OP_RD_HI && model_q.size() != 0) begin
         model_q.delete(0);
      end
   endtask

   task automatic idle_cycle();
      @(negedge rd_clk);
      verify_status();
   endtask

   // ##############################
   // stimulus table
   // ##############################
   task automatic build_table();
      addr_t hit;
      hit = mesh_addr(NODE_ID, MBOX_GROUP, REG_MBOX_LO);

      // in-order delivery, peek then pop
      repeat (3) add_row(OP_SEND, hit, 1'b1, 1'b1);
      add_row(OP_RD_LO, reg_addr(REG_MBOX_LO), 1'b0, 1'b0);
      add_row(OP_RD_HI, reg_addr(REG_MBOX_HI), 1'b0, 1'b0);
      add_row(OP_RD_LO, reg_addr(REG_MBOX_LO), 1'b0, 1'b0);
      add_row(OP_RD_HI, reg_addr(REG_MBOX_HI), 1'b0, 1'b0);
      add_row(OP_RD_HI, reg_addr(REG_MBOX_HI), 1'b0, 1'b0);
      add_row(OP_IDLE, '0, 1'b0, 1'b0);

      // address filter
      add_row(OP_SEND, hit, 1'b1, 1'b1);
      add_row(OP_SEND, mesh_addr(12'h811, MBOX_GROUP, REG_MBOX_LO), 1'b1, 1'b0);
      add_row(OP_SEND, hit, 1'b0, 1'b0);                                  // read packet
      add_row(OP_SEND, mesh_addr(NODE_ID, 3'h2, REG_MBOX_LO), 1'b1, 1'b0);
      add_row(OP_SEND, mesh_addr(NODE_ID, MBOX_GROUP, REG_MBOX_HI), 1'b1, 1'b0);
      add_row(OP_SEND, mesh_addr(NODE_ID, MBOX_GROUP, 6'd0), 1'b1, 1'b0);
      add_row(OP_RD_LO, reg_addr(REG_MBOX_LO), 1'b0, 1'b0);
      add_row(OP_RD_HI, reg_addr(REG_MBOX_HI), 1'b0, 1'b0);
      add_row(OP_SEND, mesh_addr(12'h010, MBOX_GROUP, REG_MBOX_LO), 1'b1, 1'b0);
      add_row(OP_RD_LO, reg_addr(REG_MBOX_LO), 1'b0, 1'b0);   // empty again
      add_row(OP_IDLE, '0, 1'b0, 1'b0);

      // fill, then overflow into the filter
      repeat (FIFO_DEPTH) add_row(OP_SEND, hit, 1'b1, 1'b1);
      add_row(OP_IDLE, '0, 1'b0, 1'b0);
      add_row(OP_SEND, hit, 1'b1, 1'b1);   // parks, raises packet_wait
      add_row(OP_DROP, hit, 1'b1, 1'b1);   // lost
      add_row(OP_IDLE, '0, 1'b0, 1'b0);
      add_row(OP_RD_HI, reg_addr(REG_MBOX_HI), 1'b0, 1'b0);
      add_row(OP_IDLE, '0, 1'b0, 1'b0);    // parked word moved in
      add_row(OP_RD_LO, reg_addr(REG_MBOX_LO), 1'b0, 1'b0);

      // accesses that never pop
      add_row(OP_RD_OTHER, reg_addr(6'd0), 1'b0, 1'b0);
      add_row(OP_RD_OTHER, reg_addr(6'd8), 1'b0, 1'b0);
      add_row(OP_RD_OTHER, reg_addr(6'd11), 1'b0, 1'b0);
      add_row(OP_REG_WR, reg_addr(REG_MBOX_HI), 1'b0, 1'b0);
      add_row(OP_REG_WR, reg_addr(REG_MBOX_LO), 1'b0, 1'b0);
      add_row(OP_IDLE, '0, 1'b0, 1'b0);

      // drain everything, then read while empty
      repeat (FIFO_DEPTH) add_row(OP_RD_HI, reg_addr(REG_MBOX_HI), 1'b0, 1'b0);
      add_row(OP_IDLE, '0, 1'b0, 1'b0);
      add_row(OP_RD_HI, reg_addr(REG_MBOX_HI), 1'b0, 1'b0);
      add_row(OP_RD_LO, reg_addr(REG_MBOX_LO), 1'b0, 1'b0);
      add_row(OP_IDLE, '0, 1'b0, 1'b0);
   endtask

   // ##############################
   // run control
   // ##############################
   always @(posedge rd_clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= cycle_limit) begin
         abort_run("cycle limit reached before the table finished");
      end
   end

   initial begin
      void'($urandom(32'hc2d6_ce73));
      rd_reset    = 1'b1;
      mesh_access = 1'b0;
      mesh_packet = '0;
      mi_en       = 1'b0;
      mi_we       = 1'b0;
      mi_addr     = '0;
      build_table();
      cycle_limit = rows.size() * 8 + 100;

      repeat (3) @(posedge rd_clk);
      @(negedge rd_clk);
      rd_reset = 1'b0;
      @(negedge rd_clk);
      verify_status();   // model empty, everything low

      foreach (rows[i]) begin
         case (rows[i].op)
            OP_SEND, OP_DROP: send_packet(rows[i]);
            OP_RD_LO, OP_RD_HI, OP_RD_OTHER, OP_REG_WR: reg_access(rows[i]);
            default: idle_cycle();
         endcase
      end

      $display("Simulation passed");
      $finish;
   end

endmodule

/* src.f */
mbox_pkg.sv
mbox_word_if.sv
mesh_write_filter.sv
mailbox_fifo.sv
mailbox_reg_reader.sv
emailbox_top.sv
tb_emailbox.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_emailbox
FILELIST  = src.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

# build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
